/* Bender.yml */
package:
  name: floor_logic

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/car_pkg.sv
      - common/floor_pkg.sv
      - dispatch/request_latch.sv
      - dispatch/target_selector.sv
      - src/motion_interlock.sv
      - src/floor_logic_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/floor_logic_chk.sv
      - tests/floor_logic_tb.sv

/* all.f */
+incdir+common
common/car_pkg.sv
common/floor_pkg.sv
dispatch/request_latch.sv
dispatch/target_selector.sv
src/motion_interlock.sv
src/floor_logic_top.sv
tests/floor_logic_chk.sv
tests/floor_logic_tb.sv

/* common/car_pkg.sv */
package car_pkg;

    ////////////////////
    // Car motion
    ////////////////////

    // Travel direction of the car
    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } direction_t;

endpackage

/* common/floor_logic_macros.svh */
`ifndef FLOOR_LOGIC_MACROS_SVH
`define FLOOR_LOGIC_MACROS_SVH

////////////////////
// Building size
////////////////////

// Floors served, floor one up to floor eleven
`define FLOOR_COUNT 11

// Bits needed for a floor index
`define FLOOR_W 4

////////////////////
// Door gating
////////////////////

// Clocks from a door button to its permit
`define DOOR_GATE_LATENCY 1

`endif

/* common/floor_pkg.sv */
`include "floor_logic_macros.svh"

package floor_pkg;

    ////////////////////
    // Floor encoding
    ////////////////////

    // Floor index, floor one is 0 and floor eleven is 10
    typedef logic [`FLOOR_W-1:0] floor_t;

    // One bit per floor, bit n is floor index n
    typedef logic [`FLOOR_COUNT-1:0] floor_mask_t;

    // Lowest and highest valid index
    localparam floor_t BOTTOM_FLOOR = floor_t'(0);
    localparam floor_t TOP_FLOOR = floor_t'(`FLOOR_COUNT - 1);

endpackage

/* dispatch/request_latch.sv */
`timescale 1ns/100ps
`include "floor_logic_macros.svh"

module request_latch (
    input  logic                   clock,
    input  logic                   reset_n,
    input  floor_pkg::floor_mask_t buttons,
    input  floor_pkg::floor_t      current_floor,
    input  logic                   car_moving,
    input  logic                   service_enable,
    output floor_pkg::floor_mask_t lamps
);

    import floor_pkg::*;

    floor_mask_t here_mask;
    floor_mask_t stop_mask;

    // One-hot of the floor the car is at
    always_comb begin
        here_mask = '0;
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            here_mask[i] = (current_floor == floor_t'(i));
        end
    end

    // Stopped car blocks presses at its floor and clears that lamp
    assign stop_mask = car_moving ? '0 : here_mask;

    ////////////////////
    // Lamp register
    ////////////////////

    // Every press in the cycle is latched, clear wins over set
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lamps <= '0;
        end else if (service_enable) begin
            lamps <= (lamps | buttons) & ~stop_mask;
        end
    end

endmodule

/* dispatch/target_selector.sv */
`timescale 1ns/100ps
`include "floor_logic_macros.svh"

module target_selector (
    input  logic                   clock,
    input  logic                   reset_n,
    input  floor_pkg::floor_mask_t hall_lamps,
    input  floor_pkg::floor_mask_t panel_lamps,
    input  floor_pkg::floor_t      current_floor,
    input  logic                   car_moving,
    input  logic                   service_enable,
    output floor_pkg::floor_t      target_floor,
    output car_pkg::direction_t    sweep_direction
);

    import floor_pkg::*;
    import car_pkg::*;

    floor_mask_t requests;
    floor_mask_t above;
    floor_mask_t below;
    logic        up_hit;
    logic        down_hit;
    floor_t      up_floor;
    floor_t      down_floor;
    logic        reselect;
    floor_t      next_target;
    direction_t  next_direction;

    // Hall calls and car panel share one request set
    assign requests = hall_lamps | panel_lamps;

    always_comb begin
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            above[i] = requests[i] && (floor_t'(i) > current_floor);
            below[i] = requests[i] && (floor_t'(i) < current_floor);
        end
    end

    ////////////////////
    // Nearest requests
    ////////////////////

    // Scanning downward leaves the lowest floor above the car
    always_comb begin
        up_hit   = 1'b0;
        up_floor = current_floor;
        for (int i = `FLOOR_COUNT - 1; i >= 0; i--) begin
            if (above[i]) begin
                up_hit   = 1'b1;
                up_floor = floor_t'(i);
            end
        end
    end

    // Scanning upward leaves the highest floor below the car
    always_comb begin
        down_hit   = 1'b0;
        down_floor = current_floor;
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            if (below[i]) begin
                down_hit   = 1'b1;
                down_floor = floor_t'(i);
            end
        end
    end

    ////////////////////
    // Sweep choice
    ////////////////////

    always_comb begin
        next_target    = current_floor;
        next_direction = sweep_direction;
        if (sweep_direction == DIR_UP && up_hit) begin
            next_target    = up_floor;
            next_direction = DIR_UP;
        end else if (down_hit) begin
            next_target    = down_floor;
            next_direction = DIR_DOWN;
        end else if (up_hit) begin
            next_target    = up_floor;
            next_direction = DIR_UP;
        end
    end

    // Only pick again once the car has reached its target
    assign reselect = service_enable && !car_moving && (target_floor == current_floor);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target_floor    <= BOTTOM_FLOOR;
            sweep_direction <= DIR_UP;
        end else if (reselect) begin
            target_floor    <= next_target;
            sweep_direction <= next_direction;
        end
    end

endmodule

/* src/floor_logic_top.sv */
`timescale 1ns/100ps

module floor_logic_top (
    input  logic                   clock,
    input  logic                   reset_n,
    input  floor_pkg::floor_mask_t floor_call_buttons,
    input  floor_pkg::floor_mask_t panel_buttons,
    input  logic                   door_open_btn,
    input  logic                   door_close_btn,
    input  logic                   emergency_btn,
    input  logic                   power_switch,
    input  logic                   car_moving,
    input  floor_pkg::floor_t      current_floor,
    output floor_pkg::floor_t      target_floor,
    output car_pkg::direction_t    travel_direction,
    output logic                   activate_elevator,
    output logic                   door_open_allowed,
    output logic                   door_close_allowed,
    output floor_pkg::floor_mask_t call_button_lights,
    output floor_pkg::floor_mask_t panel_button_lights
);

    logic service_enable;

    ////////////////////
    // Request lamps
    ////////////////////

    // Hall calls
    request_latch hall_bank (
        .clock          (clock),
        .reset_n        (reset_n),
        .buttons        (floor_call_buttons),
        .current_floor  (current_floor),
        .car_moving     (car_moving),
        .service_enable (service_enable),
        .lamps          (call_button_lights)
    );

    // Car panel destinations
    request_latch panel_bank (
        .clock          (clock),
        .reset_n        (reset_n),
        .buttons        (panel_buttons),
        .current_floor  (current_floor),
        .car_moving     (car_moving),
        .service_enable (service_enable),
        .lamps          (panel_button_lights)
    );

    ////////////////////
    // Dispatch
    ////////////////////

    // Stored sweep only steers the next choice, travel_direction comes from the interlock
    target_selector selector (
        .clock           (clock),
        .reset_n         (reset_n),
        .hall_lamps      (call_button_lights),
        .panel_lamps     (panel_button_lights),
        .current_floor   (current_floor),
        .car_moving      (car_moving),
        .service_enable  (service_enable),
        .target_floor    (target_floor),
        .sweep_direction ()
    );

    motion_interlock interlock (
        .clock              (clock),
        .reset_n            (reset_n),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .car_moving         (car_moving),
        .current_floor      (current_floor),
        .target_floor       (target_floor),
        .service_enable     (service_enable),
        .activate_elevator  (activate_elevator),
        .travel_direction   (travel_direction),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

/* src/motion_interlock.sv */
`timescale 1ns/100ps
`include "floor_logic_macros.svh"

module motion_interlock (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                power_switch,
    input  logic                emergency_btn,
    input  logic                door_open_btn,
    input  logic                door_close_btn,
    input  logic                car_moving,
    input  floor_pkg::floor_t   current_floor,
    input  floor_pkg::floor_t   target_floor,
    output logic                service_enable,
    output logic                activate_elevator,
    output car_pkg::direction_t travel_direction,
    output logic                door_open_allowed,
    output logic                door_close_allowed
);

    import car_pkg::*;

    // Open permit in bit 1, close permit in bit 0
    logic [1:0] door_pipe [`DOOR_GATE_LATENCY];
    logic       door_gate;

    assign service_enable = power_switch && !emergency_btn;

    // Level request held until the car starts moving
    assign activate_elevator = service_enable && !car_moving && (target_floor != current_floor);
    assign travel_direction = (target_floor > current_floor) ? DIR_UP : DIR_DOWN;

    ////////////////////
    // Door permits
    ////////////////////

    assign door_gate = power_switch && !car_moving;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `DOOR_GATE_LATENCY; i++) begin
                door_pipe[i] <= 2'b00;
            end
        end else begin
            door_pipe[0] <= {door_open_btn && door_gate, door_close_btn && door_gate};
            for (int i = 1; i < `DOOR_GATE_LATENCY; i++) begin
                door_pipe[i] <= door_pipe[i-1];
            end
        end
    end

    assign door_open_allowed  = door_pipe[`DOOR_GATE_LATENCY-1][1];
    assign door_close_allowed = door_pipe[`DOOR_GATE_LATENCY-1][0];

endmodule

/* tests/floor_logic_chk.sv */
`timescale 1ns/100ps

module floor_logic_chk (
    input logic                   clock,
    input logic                   reset_n,
    input logic                   car_moving,
    input logic                   power_switch,
    input logic                   service_enable,
    input logic                   activate_elevator,
    input floor_pkg::floor_mask_t call_button_lights,
    input floor_pkg::floor_mask_t panel_button_lights
);

    ////////////////////
    // Car handshake
    ////////////////////

    activate_while_moving: assert property (
        @(posedge clock) disable iff (!reset_n) car_moving |-> !activate_elevator
    ) else $error("activate request raised while the car is moving");

    activate_without_power: assert property (
        @(posedge clock) disable iff (!reset_n) !power_switch |-> !activate_elevator
    ) else $error("activate request raised while power is off");

    ////////////////////
    // Lamps
    ////////////////////

    // Lamp banks hold while service is off
    lamp_rise_disabled: assert property (
        @(posedge clock) disable iff (!reset_n)
        !service_enable |=>
            ((call_button_lights & ~$past(call_button_lights)) == '0) &&
            ((panel_button_lights & ~$past(panel_button_lights)) == '0)
    ) else $error("a lamp rose while service is disabled");

endmodule

bind floor_logic_top floor_logic_chk chk (
    .clock               (clock),
    .reset_n             (reset_n),
    .car_moving          (car_moving),
    .power_switch        (power_switch),
    .service_enable      (service_enable),
    .activate_elevator   (activate_elevator),
    .call_button_lights  (call_button_lights),
    .panel_button_lights (panel_button_lights)
);

/* tests/floor_logic_tb.sv */
`timescale 1ns/100ps
`include "floor_logic_macros.svh"

module floor_logic_tb;

    import floor_pkg::*;
    import car_pkg::*;

    localparam int TRIPS = 40;
    localparam int ACTIVATE_TIMEOUT = 300;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    logic        car_moving;
    floor_t      current_floor;
    floor_t      target_floor;
    direction_t  travel_direction;
    logic        activate_elevator;
    logic        door_open_allowed;
    logic        door_close_allowed;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;

    // Reference model state
    floor_mask_t m_hall;
    floor_mask_t m_panel;
    floor_t      m_target;
    direction_t  m_dir;
    logic        m_open;
    logic        m_close;

    // Emulated car and pulse counters
    logic   car_next_moving;
    floor_t car_next_floor;
    int     power_off_left;
    int     emergency_left;

    floor_logic_top uut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    ////////////////////
    // Failure reporting
    ////////////////////

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_mask(input string name, input floor_mask_t exp, input floor_mask_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_floor(input string name, input floor_t exp, input floor_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t ns %s expected %0d actual %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_direction(input string name, input direction_t exp,
                                   input direction_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t ns %s expected %s actual %s", $time, name, exp.name(),
                     act.name());
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %0t ns %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    // Sweep rule, keep going up while there is work above
    task automatic choose_next(input floor_mask_t reqs, input floor_t cur, input direction_t dir,
                               output floor_t t, output direction_t d);
        logic   up_found;
        logic   down_found;
        floor_t lowest_above;
        floor_t highest_below;
        up_found = 1'b0;
        down_found = 1'b0;
        lowest_above = cur;
        highest_below = cur;
        for (int i = `FLOOR_COUNT - 1; i > cur; i--) begin
            if (reqs[i]) begin
                up_found = 1'b1;
                lowest_above = floor_t'(i);
            end
        end
        for (int i = 0; i < cur; i++) begin
            if (reqs[i]) begin
                down_found = 1'b1;
                highest_below = floor_t'(i);
            end
        end
        t = cur;
        d = dir;
        if (dir == DIR_UP && up_found) begin
            t = lowest_above;
        end else if (down_found) begin
            t = highest_below;
            d = DIR_DOWN;
        end else if (up_found) begin
            t = lowest_above;
            d = DIR_UP;
        end
    endtask

    // Runs at the clock edge on the inputs the DUT samples there
    task automatic update_model();
        floor_mask_t stop;
        floor_t      t;
        direction_t  d;
        logic        svc;
        svc = power_switch && !emergency_btn;
        stop = '0;
        if (!car_moving) stop[current_floor] = 1'b1;
        if (svc && !car_moving && m_target == current_floor) begin
            choose_next(m_hall | m_panel, current_floor, m_dir, t, d);
            m_target = t;
            m_dir = d;
        end
        if (svc) begin
            m_hall = (m_hall | floor_call_buttons) & ~stop;
            m_panel = (m_panel | panel_buttons) & ~stop;
        end
        m_open = door_open_btn && power_switch && !car_moving;
        m_close = door_close_btn && power_switch && !car_moving;
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    function automatic floor_mask_t sparse_mask();
        floor_mask_t m;
        m = '0;
        if ($urandom % 4 == 0) m[$urandom % `FLOOR_COUNT] = 1'b1;
        if ($urandom % 16 == 0) m[$urandom % `FLOOR_COUNT] = 1'b1;
        return m;
    endfunction

    task automatic drive_inputs();
        if (power_off_left > 0) power_off_left--;
        else if ($urandom % 50 == 0) power_off_left = 1 + $urandom % 3;
        if (emergency_left > 0) emergency_left--;
        else if ($urandom % 40 == 0) emergency_left = 1 + $urandom % 3;
        floor_call_buttons = sparse_mask();
        panel_buttons = sparse_mask();
        power_switch = (power_off_left == 0);
        emergency_btn = (emergency_left != 0);
        door_open_btn = $urandom % 2;
        door_close_btn = $urandom % 2;
        car_moving = car_next_moving;
        current_floor = car_next_floor;
    endtask

    task automatic check_outputs();
        logic       exp_activate;
        direction_t exp_dir;
        exp_activate = power_switch && !emergency_btn && !car_moving &&
                       (m_target != current_floor);
        exp_dir = (m_target > current_floor) ? DIR_UP : DIR_DOWN;
        check_mask("call_button_lights", m_hall, call_button_lights);
        check_mask("panel_button_lights", m_panel, panel_button_lights);
        check_floor("target_floor", m_target, target_floor);
        check_direction("travel_direction", exp_dir, travel_direction);
        check_bit("activate_elevator", exp_activate, activate_elevator);
        check_bit("door_open_allowed", m_open, door_open_allowed);
        check_bit("door_close_allowed", m_close, door_close_allowed);
    endtask

    // Drive 1 ns after the edge, compare 1 ns before the next one
    task automatic step_cycle();
        @(posedge clock);
        update_model();
        #1;
        drive_inputs();
        #2;
        check_outputs();
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int     waited;
        int     hold;
        floor_t seen_target;
        void'($urandom(68));
        reset_n = 1'b0;
        floor_call_buttons = '0;
        panel_buttons = '0;
        door_open_btn = 1'b0;
        door_close_btn = 1'b0;
        emergency_btn = 1'b0;
        power_switch = 1'b1;
        car_moving = 1'b0;
        current_floor = BOTTOM_FLOOR;
        car_next_moving = 1'b0;
        car_next_floor = BOTTOM_FLOOR;
        power_off_left = 0;
        emergency_left = 0;
        m_hall = '0;
        m_panel = '0;
        m_target = BOTTOM_FLOOR;
        m_dir = DIR_UP;
        m_open = 1'b0;
        m_close = 1'b0;

        repeat (8) @(posedge clock);
        #1;
        reset_n = 1'b1;
        #2;
        check_outputs();

        for (int trip = 0; trip < TRIPS; trip++) begin
            // Idle at the floor until a request goes out
            waited = 0;
            while (!activate_elevator) begin
                step_cycle();
                waited++;
                if (waited > ACTIVATE_TIMEOUT) begin
                    $display("activate_elevator did not rise within %0d cycles",
                             ACTIVATE_TIMEOUT);
                    abort_run();
                end
            end
            seen_target = target_floor;
            hold = 2 + $urandom % 5;
            car_next_moving = 1'b1;
            for (int i = 0; i < hold; i++) begin
                step_cycle();
            end
            // Arrive at the sampled target
            car_next_moving = 1'b0;
            car_next_floor = seen_target;
            step_cycle();
        end

        $display("Done: no errors");
        $finish;
    end

endmodule
